// File: common/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// datapath and address width
`define CORE_XLEN 16

// eight general registers
`define CORE_RADDR 3

// signed immediate in the low byte
`define CORE_IMM_W 8

// shift amount in the low nibble
`define CORE_SHAMT_W 4

// first fetch address
`define CORE_PC_RESET 0

`endif

// File: common/core_pkg.sv
`include "core_config.svh"

package core_pkg;

    typedef logic [`CORE_XLEN-1:0]  word_t;     // data or address word
    typedef logic [`CORE_RADDR-1:0] reg_addr_t; // register number

    typedef enum logic [1:0] {
        CLASS_LOAD = 2'b00, CLASS_STORE = 2'b01, CLASS_LOADI = 2'b10, CLASS_REGOP = 2'b11
    } inst_class_e;

    // values match the funct field of register operations
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0, ALU_SUB = 4'd1, ALU_AND = 4'd2, ALU_OR = 4'd3,
        ALU_XOR = 4'd4, ALU_SLL = 4'd8, ALU_SRL = 4'd9,
        ALU_PASS_IMM = 4'd15 // load immediate
    } alu_op_e;

    typedef enum logic [1:0] {WB_ALU = 2'd0, WB_MEM = 2'd1, WB_IMM = 2'd2} wb_src_e;

    typedef enum logic [1:0] {FWD_REG = 2'd0, FWD_EXMEM = 2'd1, FWD_WB = 2'd2} fwd_sel_e;

    typedef struct packed {
        word_t inst;
    } if_id_t;

    typedef struct packed {
        reg_addr_t                ra;
        reg_addr_t                rb;
        word_t                    a_val;       // register file value of ra
        word_t                    b_val;       // register file value of rb
        word_t                    imm;         // sign extended
        logic [`CORE_SHAMT_W-1:0] shamt;
        alu_op_e                  alu_op;
        logic                     alu_src_imm; // immediate replaces ra operand
        reg_addr_t                dest;
        logic                     reg_write;
        logic                     mem_write;
        logic                     mem_read;
        wb_src_e                  wb_src;
    } id_ex_t;

    typedef struct packed {
        word_t     result;     // alu result or memory address
        word_t     store_data;
        reg_addr_t dest;
        logic      reg_write;
        logic      mem_write;
        logic      mem_read;
        wb_src_e   wb_src;
    } ex_mem_t;

    typedef struct packed {
        word_t     result;
        word_t     mem_data;
        word_t     imm;
        reg_addr_t dest;
        logic      reg_write;
        wb_src_e   wb_src;
    } mem_wb_t;

endpackage

// File: hdl/fetch_stage.sv
`include "core_config.svh"

module fetch_stage import core_pkg::*; (
    input  logic   clock,
    input  logic   reset_ALUop_2_3,
    input  logic   load_stall,
    input  word_t  inst,
    output word_t  pc_addr,
    output if_id_t if_id
);

    word_t pc;

    assign pc_addr = pc; // instruction memory reads this combinationally

    // no branches, so the pc only counts up or holds
    always_ff @(posedge clock or posedge reset_ALUop_2_3) begin
        if (reset_ALUop_2_3) begin
            pc <= word_t'(`CORE_PC_RESET);
        end else if (!load_stall) begin
            pc <= pc + 1'b1;
        end
    end

    always_ff @(posedge clock or posedge reset_ALUop_2_3) begin
        if (reset_ALUop_2_3) begin
            if_id <= '0; // all-zero word is the nop
        end else if (!load_stall) begin
            if_id.inst <= inst;
        end
    end

endmodule

// File: hdl/decode_stage.sv
`include "core_config.svh"

module decode_stage import core_pkg::*; (
    input  logic      clock,
    input  logic      reset_ALUop_2_3,
    input  if_id_t    if_id,
    output reg_addr_t rd_addr_a,
    output reg_addr_t rd_addr_b,
    input  word_t     rd_data_a,
    input  word_t     rd_data_b,
    output logic      load_stall,
    output id_ex_t    id_ex
);

    inst_class_e cls;
    reg_addr_t   ra;
    reg_addr_t   rb;
    logic [3:0]  funct;
    logic        reads_a;
    logic        reads_b;
    id_ex_t      dec;

    assign cls   = inst_class_e'(if_id.inst[15:14]);
    assign ra    = if_id.inst[13:11];
    assign rb    = if_id.inst[10:8];
    assign funct = if_id.inst[7:4];

    assign rd_addr_a = ra;
    assign rd_addr_b = rb;

    always_comb begin
        dec       = '0;
        dec.ra    = ra;
        dec.rb    = rb;
        dec.a_val = rd_data_a;
        dec.b_val = rd_data_b;
        dec.imm   = {{(`CORE_XLEN-`CORE_IMM_W){if_id.inst[`CORE_IMM_W-1]}},
                     if_id.inst[`CORE_IMM_W-1:0]};
        dec.shamt = if_id.inst[`CORE_SHAMT_W-1:0];
        dec.dest  = rb;
        case (cls)
            CLASS_LOAD: begin
                dec.alu_op      = ALU_ADD; // address is rb + imm
                dec.alu_src_imm = 1'b1;
                dec.dest        = ra;
                dec.reg_write   = 1'b1;
                dec.mem_read    = 1'b1;
                dec.wb_src      = WB_MEM;
            end
            CLASS_STORE: begin
                dec.alu_op      = ALU_ADD;
                dec.alu_src_imm = 1'b1;
                dec.mem_write   = 1'b1;
            end
            CLASS_LOADI: begin
                dec.alu_op    = ALU_PASS_IMM;
                dec.reg_write = 1'b1;
                dec.wb_src    = WB_IMM;
            end
            CLASS_REGOP: begin
                dec.wb_src = WB_ALU;
                case (funct)
                    4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd8, 4'd9: begin
                        dec.alu_op    = alu_op_e'(funct);
                        dec.reg_write = 1'b1;
                    end
                    default: dec.alu_op = ALU_ADD; // unknown funct writes nothing
                endcase
            end
        endcase
    end

    // load immediate reads no register, loads read only rb
    assign reads_a = (cls == CLASS_STORE) || (cls == CLASS_REGOP);
    assign reads_b = (cls != CLASS_LOADI);

    assign load_stall = id_ex.mem_read && (id_ex.dest != '0) &&
                        ((reads_a && (ra == id_ex.dest)) || (reads_b && (rb == id_ex.dest)));

    always_ff @(posedge clock or posedge reset_ALUop_2_3) begin
        if (reset_ALUop_2_3) begin
            id_ex <= '0;
        end else if (load_stall) begin
            id_ex <= '0; // bubble, no write flags
        end else begin
            id_ex <= dec;
        end
    end

endmodule

// File: hdl/register_file.sv
module register_file import core_pkg::*; (
    input  logic      clock,
    input  logic      reset_ALUop_2_3,
    input  reg_addr_t rd_addr_a,
    input  reg_addr_t rd_addr_b,
    output word_t     rd_data_a,
    output word_t     rd_data_b,
    input  logic      wr_en,
    input  reg_addr_t wr_addr,
    input  word_t     wr_data
);

    word_t regs [1:7]; // r0 is not stored

    // new value is visible in the cycle it is written
    function automatic word_t read_port(input reg_addr_t addr);
        word_t value;
        if (addr == '0) begin
            value = '0;
        end else if (wr_en && (wr_addr == addr)) begin
            value = wr_data;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        rd_data_a = read_port(rd_addr_a);
        rd_data_b = read_port(rd_addr_b);
    end

    always_ff @(posedge clock or posedge reset_ALUop_2_3) begin
        if (reset_ALUop_2_3) begin
            for (int i = 1; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data; // writes to r0 dropped
        end
    end

endmodule

// File: hdl/execute_stage.sv
module execute_stage import core_pkg::*; (
    input  logic      clock,
    input  logic      reset_ALUop_2_3,
    input  id_ex_t    id_ex,
    input  logic      wb_en,
    input  reg_addr_t wb_addr,
    input  word_t     wb_data,
    output ex_mem_t   ex_mem,
    output word_t     mem_addr,
    output word_t     mem_write_data,
    output logic      mem_write
);

    fwd_sel_e sel_a;
    fwd_sel_e sel_b;
    word_t    op_a;     // ra after forwarding
    word_t    op_b;     // rb after forwarding
    word_t    alu_src;
    word_t    result;

    // the newer producer in ex_mem wins over write-back
    function automatic fwd_sel_e fwd_select(input reg_addr_t src_reg);
        fwd_sel_e sel;
        if (ex_mem.reg_write && !ex_mem.mem_read && (ex_mem.dest != '0) &&
            (ex_mem.dest == src_reg)) begin
            sel = FWD_EXMEM;
        end else if (wb_en && (wb_addr != '0) && (wb_addr == src_reg)) begin
            sel = FWD_WB;
        end else begin
            sel = FWD_REG;
        end
        return sel;
    endfunction

    function automatic word_t fwd_value(input fwd_sel_e sel, input word_t reg_val);
        word_t value;
        case (sel)
            FWD_EXMEM: value = ex_mem.result;
            FWD_WB:    value = wb_data;
            default:   value = reg_val;
        endcase
        return value;
    endfunction

    always_comb begin
        sel_a = fwd_select(id_ex.ra);
        sel_b = fwd_select(id_ex.rb);
        op_a  = fwd_value(sel_a, id_ex.a_val);
        op_b  = fwd_value(sel_b, id_ex.b_val);
    end

    assign alu_src = id_ex.alu_src_imm ? id_ex.imm : op_a;

    // rb is always the left operand
    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD:      result = op_b + alu_src;
            ALU_SUB:      result = op_b - alu_src;
            ALU_AND:      result = op_b & alu_src;
            ALU_OR:       result = op_b | alu_src;
            ALU_XOR:      result = op_b ^ alu_src;
            ALU_SLL:      result = op_b << id_ex.shamt;
            ALU_SRL:      result = op_b >> id_ex.shamt;
            ALU_PASS_IMM: result = id_ex.imm;
            default:      result = '0;
        endcase
    end

    always_ff @(posedge clock or posedge reset_ALUop_2_3) begin
        if (reset_ALUop_2_3) begin
            ex_mem <= '0;
        end else begin
            ex_mem.result     <= result;
            ex_mem.store_data <= op_a; // stores write ra
            ex_mem.dest       <= id_ex.dest;
            ex_mem.reg_write  <= id_ex.reg_write;
            ex_mem.mem_write  <= id_ex.mem_write;
            ex_mem.mem_read   <= id_ex.mem_read;
            ex_mem.wb_src     <= id_ex.wb_src;
        end
    end

    assign mem_addr       = ex_mem.result;
    assign mem_write_data = ex_mem.store_data;
    assign mem_write      = ex_mem.mem_write;

endmodule

// File: hdl/writeback_stage.sv
module writeback_stage import core_pkg::*; (
    input  logic      clock,
    input  logic      reset_ALUop_2_3,
    input  ex_mem_t   ex_mem,
    input  word_t     mem_read_data,
    output logic      wb_en,
    output reg_addr_t wb_addr,
    output word_t     wb_data
);

    mem_wb_t mem_wb;

    always_ff @(posedge clock or posedge reset_ALUop_2_3) begin
        if (reset_ALUop_2_3) begin
            mem_wb <= '0;
        end else begin
            mem_wb.result    <= ex_mem.result;
            mem_wb.mem_data  <= mem_read_data;
            mem_wb.dest      <= ex_mem.dest;
            mem_wb.reg_write <= ex_mem.reg_write;
            mem_wb.wb_src    <= ex_mem.wb_src;
        end
    end

    always_comb begin
        case (mem_wb.wb_src)
            WB_MEM:  wb_data = mem_wb.mem_data;
            default: wb_data = mem_wb.result; // load immediate passes through the alu
        endcase
    end

    assign wb_en   = mem_wb.reg_write;
    assign wb_addr = mem_wb.dest;

endmodule

// File: hdl/core_top.sv
module core_top import core_pkg::*; (
    input  logic  clock,
    input  logic  reset_ALUop_2_3,
    output word_t pc_addr,
    input  word_t inst,
    output word_t mem_addr,
    output word_t mem_write_data,
    output logic  mem_write,
    input  word_t mem_read_data
);

    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    logic      load_stall;
    reg_addr_t rd_addr_a;
    reg_addr_t rd_addr_b;
    word_t     rd_data_a;
    word_t     rd_data_b;
    logic      wb_en;     // write port, also fed back for forwarding
    reg_addr_t wb_addr;
    word_t     wb_data;

    fetch_stage u_fetch (
        .clock           (clock),
        .reset_ALUop_2_3 (reset_ALUop_2_3),
        .load_stall      (load_stall),
        .inst            (inst),
        .pc_addr         (pc_addr),
        .if_id           (if_id)
    );

    decode_stage u_decode (
        .clock           (clock),
        .reset_ALUop_2_3 (reset_ALUop_2_3),
        .if_id           (if_id),
        .rd_addr_a       (rd_addr_a),
        .rd_addr_b       (rd_addr_b),
        .rd_data_a       (rd_data_a),
        .rd_data_b       (rd_data_b),
        .load_stall      (load_stall),
        .id_ex           (id_ex)
    );

    register_file u_regs (
        .clock           (clock),
        .reset_ALUop_2_3 (reset_ALUop_2_3),
        .rd_addr_a       (rd_addr_a),
        .rd_addr_b       (rd_addr_b),
        .rd_data_a       (rd_data_a),
        .rd_data_b       (rd_data_b),
        .wr_en           (wb_en),
        .wr_addr         (wb_addr),
        .wr_data         (wb_data)
    );

    execute_stage u_execute (
        .clock           (clock),
        .reset_ALUop_2_3 (reset_ALUop_2_3),
        .id_ex           (id_ex),
        .wb_en           (wb_en),
        .wb_addr         (wb_addr),
        .wb_data         (wb_data),
        .ex_mem          (ex_mem),
        .mem_addr        (mem_addr),
        .mem_write_data  (mem_write_data),
        .mem_write       (mem_write)
    );

    writeback_stage u_writeback (
        .clock           (clock),
        .reset_ALUop_2_3 (reset_ALUop_2_3),
        .ex_mem          (ex_mem),
        .mem_read_data   (mem_read_data),
        .wb_en           (wb_en),
        .wb_addr         (wb_addr),
        .wb_data         (wb_data)
    );

endmodule

// File: sim/core_checker.sv
module core_checker import core_pkg::*; (
    input  logic  clock,
    input  logic  reset_ALUop_2_3,
    input  word_t pc_addr,
    input  word_t mem_addr,
    input  word_t mem_write_data,
    input  logic  mem_write,
    output int    fail_count
);

    localparam int PROG_LEN  = 64;
    localparam int MEM_DEPTH = 256;

    word_t prog     [0:PROG_LEN-1];
    word_t mem_init [0:MEM_DEPTH-1];
    word_t exp_addr [0:PROG_LEN-1];
    word_t exp_data [0:PROG_LEN-1];
    int    exp_count;
    int    exp_stalls;
    int    store_idx;
    int    hold_count;
    int    err_count;
    int    pass_count = 0;
    int    cur_test;
    logic  active = 1'b0;
    logic  after_reset;  // next sampled cycle is the first one out of reset
    word_t prev_pc;
    string first_error;

    task automatic load_program_word(input int idx, input word_t word);
        prog[idx] = word;
    endtask

    task automatic load_data_word(input int idx, input word_t word);
        mem_init[idx] = word;
    endtask

    task automatic record_error(input string msg);
        if (err_count == 0) begin
            first_error = msg;
        end
        err_count++;
    endtask

    // instruction set model in program order
    task automatic run_model();
        word_t       regs [0:7];
        word_t       mem  [0:MEM_DEPTH-1];
        word_t       w;
        word_t       imm;
        word_t       addr;
        word_t       res;
        inst_class_e cls;
        reg_addr_t   ra;
        reg_addr_t   rb;
        reg_addr_t   prev_dest;
        logic        prev_load;
        logic        uses_prev;
        logic        writes;
        for (int r = 0; r < 8; r++) begin
            regs[r] = '0;
        end
        for (int m = 0; m < MEM_DEPTH; m++) begin
            mem[m] = mem_init[m];
        end
        exp_count  = 0;
        exp_stalls = 0;
        prev_load  = 1'b0;
        prev_dest  = '0;
        for (int i = 0; i < PROG_LEN; i++) begin
            w   = prog[i];
            cls = inst_class_e'(w[15:14]);
            ra  = w[13:11];
            rb  = w[10:8];
            imm = {{8{w[7]}}, w[7:0]};
            case (cls)
                CLASS_LOAD:  uses_prev = (rb == prev_dest);
                CLASS_LOADI: uses_prev = 1'b0;
                default:     uses_prev = (ra == prev_dest) || (rb == prev_dest);
            endcase
            if (prev_load && (prev_dest != '0) && uses_prev) begin
                exp_stalls++;
            end
            prev_load = (cls == CLASS_LOAD);
            prev_dest = ra;
            case (cls)
                CLASS_LOAD: begin
                    addr = regs[rb] + imm;
                    if (ra != '0) begin
                        regs[ra] = mem[addr[7:0]];
                    end
                end
                CLASS_STORE: begin
                    addr                = regs[rb] + imm;
                    exp_addr[exp_count] = addr;
                    exp_data[exp_count] = regs[ra];
                    exp_count++;
                    mem[addr[7:0]]      = regs[ra];
                end
                CLASS_LOADI: begin
                    if (rb != '0) begin
                        regs[rb] = imm;
                    end
                end
                default: begin
                    writes = 1'b1;
                    res    = '0;
                    case (w[7:4])
                        4'd0:    res = regs[rb] + regs[ra];
                        4'd1:    res = regs[rb] - regs[ra];
                        4'd2:    res = regs[rb] & regs[ra];
                        4'd3:    res = regs[rb] | regs[ra];
                        4'd4:    res = regs[rb] ^ regs[ra];
                        4'd8:    res = regs[rb] << w[3:0];
                        4'd9:    res = regs[rb] >> w[3:0];
                        default: writes = 1'b0;
                    endcase
                    if (writes && (rb != '0)) begin
                        regs[rb] = res;
                    end
                end
            endcase
        end
    endtask

    task automatic start_test(input int test_no);
        cur_test = test_no;
        run_model();
        store_idx   = 0;
        hold_count  = 0;
        err_count   = 0;
        after_reset = 1'b1;
        active      = 1'b1;
    endtask

    task automatic finish_test(input int test_no);
        if (store_idx != exp_count) begin
            record_error($sformatf("Fail test %0d: store count expected 0x%0h got 0x%0h",
                                   test_no, exp_count, store_idx));
        end
        if (hold_count != exp_stalls) begin
            record_error($sformatf("Fail test %0d: pc_addr hold count expected 0x%0h got 0x%0h",
                                   test_no, exp_stalls, hold_count));
        end
        active = 1'b0;
        if (err_count == 0) begin
            pass_count++;
            $display("Pass test %0d: %0d stores, %0d load-use stalls",
                     test_no, exp_count, exp_stalls);
        end else begin
            fail_count++;
            $display("%s (%0d errors in this test)", first_error, err_count);
        end
    endtask

    task automatic print_totals();
        $display("Tests: %0d, passed: %0d, failed: %0d",
                 pass_count + fail_count, pass_count, fail_count);
    endtask

    always @(posedge clock) begin
        if (active && reset_ALUop_2_3) begin
            if (mem_write !== 1'b0) begin
                record_error($sformatf("Fail test %0d: mem_write in reset expected 0x0 got 0x%h",
                                       cur_test, mem_write));
            end
            after_reset = 1'b1;
        end else if (active) begin
            if (after_reset) begin
                if (pc_addr !== '0) begin
                    record_error($sformatf("Fail test %0d: pc_addr expected 0x0000 got 0x%h",
                                           cur_test, pc_addr));
                end
            end else if (pc_addr == prev_pc) begin
                hold_count++;                         // load-use stall
            end else if (pc_addr != prev_pc + 16'd1) begin
                record_error($sformatf("Fail test %0d: pc_addr expected 0x%h or 0x%h got 0x%h",
                                       cur_test, prev_pc, prev_pc + 16'd1, pc_addr));
            end
            prev_pc     = pc_addr;
            after_reset = 1'b0;
            if (mem_write === 1'b1) begin
                if (store_idx >= exp_count) begin
                    record_error($sformatf("Fail test %0d: the core stored to 0x%h after the %s",
                                           cur_test, mem_addr, "last expected store"));
                end else begin
                    if (mem_addr !== exp_addr[store_idx]) begin
                        record_error($sformatf("Fail test %0d: mem_addr expected 0x%h got 0x%h",
                                               cur_test, exp_addr[store_idx], mem_addr));
                    end
                    if (mem_write_data !== exp_data[store_idx]) begin
                        record_error($sformatf(
                            "Fail test %0d: mem_write_data expected 0x%h got 0x%h",
                            cur_test, exp_data[store_idx], mem_write_data));
                    end
                end
                store_idx++;
            end
        end
    end

endmodule

// File: sim/core_asserts.sv
module core_asserts import core_pkg::*; (
    input logic  clock,
    input logic  reset_ALUop_2_3,
    input word_t pc_addr,
    input logic  mem_write
);

    a_no_store_in_reset: assert property (
        @(posedge clock) reset_ALUop_2_3 |-> !mem_write
    ) else $error("mem_write was high while reset was asserted");

    a_pc_starts_at_zero: assert property (
        @(posedge clock) $fell(reset_ALUop_2_3) |-> (pc_addr == '0)
    ) else $error("pc_addr was not zero in the first cycle after reset");

    // no branches, so only hold or count up
    a_pc_step: assert property (
        @(posedge clock) disable iff (reset_ALUop_2_3)
        (pc_addr == $past(pc_addr)) || (pc_addr == $past(pc_addr) + 16'd1)
    ) else $error("pc_addr changed by something other than zero or one");

    a_mem_write_known: assert property (
        @(posedge clock) !$isunknown(mem_write)
    ) else $error("mem_write was unknown");

endmodule

// File: sim/core_tb.sv
module core_tb import core_pkg::*; ();

    localparam int          PROG_LEN     = 64;
    localparam int          MEM_DEPTH    = 256;
    localparam int          NUM_TESTS    = 3;
    localparam int          RESET_CYCLES = 10;
    localparam int          DRAIN        = 6;        // fetch of the last word until its store
    localparam logic [31:0] SEED         = 32'h6d07;

    logic        clock = 1'b0;
    logic        reset_ALUop_2_3;
    word_t       pc_addr;
    word_t       inst;
    word_t       mem_addr;
    word_t       mem_write_data;
    word_t       mem_read_data;
    logic        mem_write;
    int          fail_count;
    logic [31:0] lfsr_state;
    word_t       imem      [0:MEM_DEPTH-1] = '{default: '0};
    word_t       dmem      [0:MEM_DEPTH-1] = '{default: '0};
    word_t       dmem_init [0:MEM_DEPTH-1] = '{default: '0};

    always #5 clock = ~clock;

    assign inst          = imem[pc_addr[7:0]];  // combinational fetch
    assign mem_read_data = dmem[mem_addr[7:0]];

    always @(posedge clock) begin
        if (reset_ALUop_2_3) begin
            for (int i = 0; i < MEM_DEPTH; i++) begin
                dmem[i] <= dmem_init[i]; // fresh contents for each test
            end
        end else if (mem_write) begin
            dmem[mem_addr[7:0]] <= mem_write_data;
        end
    end

    core_top uut (
        .clock           (clock),
        .reset_ALUop_2_3 (reset_ALUop_2_3),
        .pc_addr         (pc_addr),
        .inst            (inst),
        .mem_addr        (mem_addr),
        .mem_write_data  (mem_write_data),
        .mem_write       (mem_write),
        .mem_read_data   (mem_read_data)
    );

    core_checker u_check (
        .clock           (clock),
        .reset_ALUop_2_3 (reset_ALUop_2_3),
        .pc_addr         (pc_addr),
        .mem_addr        (mem_addr),
        .mem_write_data  (mem_write_data),
        .mem_write       (mem_write),
        .fail_count      (fail_count)
    );

    bind core_top core_asserts u_asserts (
        .clock           (clock),
        .reset_ALUop_2_3 (reset_ALUop_2_3),
        .pc_addr         (pc_addr),
        .mem_write       (mem_write)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    // one lfsr step per bit
    function automatic logic [15:0] take_bits(input int count);
        logic [15:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits       = {bits[14:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    function automatic inst_class_e pick_class(input int test_no, input logic [3:0] pick);
        inst_class_e cls;
        case (test_no)
            1:       cls = (pick < 5) ? CLASS_LOADI : (pick < 11) ? CLASS_REGOP : CLASS_STORE;
            2:       cls = (pick < 6) ? CLASS_LOAD : (pick < 11) ? CLASS_STORE :
                           (pick < 13) ? CLASS_LOADI : CLASS_REGOP;
            default: cls = (pick < 4) ? CLASS_LOAD : (pick < 7) ? CLASS_STORE :
                           (pick < 10) ? CLASS_LOADI : CLASS_REGOP;
        endcase
        return cls;
    endfunction

    function automatic logic [3:0] valid_funct(input logic [2:0] n);
        return (n < 5) ? {1'b0, n} : (n == 3'd5) ? 4'd8 : 4'd9;
    endfunction

    task automatic build_program(input int test_no);
        int          reg_bits;
        inst_class_e cls;
        logic [2:0]  ra;
        logic [2:0]  rb;
        logic [7:0]  low;
        reg_bits = (test_no == 3) ? 2 : 3; // r0..r3 only, so dependencies pile up
        for (int i = 0; i < MEM_DEPTH; i++) begin
            imem[i]      = '0;               // nop
            dmem_init[i] = take_bits(16);
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            cls = pick_class(test_no, 4'(take_bits(4)));
            ra  = 3'(take_bits(reg_bits));
            rb  = 3'(take_bits(reg_bits));
            if (cls != CLASS_REGOP) begin
                low = 8'(take_bits(8));
            end else if (test_no == 3) begin
                low = 8'(take_bits(8));      // unknown funct codes too
            end else begin
                low = {valid_funct(3'(take_bits(3))), 4'(take_bits(4))};
            end
            imem[i] = {cls, ra, rb, low};
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            u_check.load_program_word(i, imem[i]);
        end
        for (int i = 0; i < MEM_DEPTH; i++) begin
            u_check.load_data_word(i, dmem_init[i]);
        end
    endtask

    initial begin
        reset_ALUop_2_3 = 1'b1;
        lfsr_state      = SEED;
        for (int t = 1; t <= NUM_TESTS; t++) begin
            reset_ALUop_2_3 = 1'b1;
            build_program(t);
            u_check.start_test(t);
            repeat (RESET_CYCLES) @(negedge clock);
            reset_ALUop_2_3 = 1'b0;
            while (pc_addr < PROG_LEN + DRAIN) begin
                @(negedge clock);
            end
            u_check.finish_test(t);
        end
        u_check.print_totals();
        if (fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // worst case is one stall per program word
    initial begin
        #(NUM_TESTS * (2 * PROG_LEN + 30) * 10);
        $display("Watchdog: the tests did not reach the end of their programs in time");
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: sim.f
+incdir+common
common/core_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/register_file.sv
hdl/execute_stage.sv
hdl/writeback_stage.sv
hdl/core_top.sv
sim/core_checker.sv
sim/core_asserts.sv
sim/core_tb.sv

// File: Bender.yml
package:
  name: core

sources:
  - include_dirs:
      - common
    files:
      - common/core_pkg.sv
      - hdl/fetch_stage.sv
      - hdl/decode_stage.sv
      - hdl/register_file.sv
      - hdl/execute_stage.sv
      - hdl/writeback_stage.sv
      - hdl/core_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - sim/core_checker.sv
      - sim/core_asserts.sv
      - sim/core_tb.sv
